//--- source/tq_pkg.sv
package tq_pkg;

    // Quantized input level, signed.
    localparam int LEVEL_W = 13;

    // Hadamard output and dequantized coefficient, signed.
    localparam int COEFF_W = 15;

    localparam int QP_W    = 6;   // Full qp.
    localparam int QPDIV_W = 4;   // Qp div 6.
    localparam int QPMOD_W = 3;   // Qp mod 6.

    // Highest legal qp.
    localparam int QP_MAX  = 51;

endpackage

//--- source/tq_qp_split.sv
`timescale 1ns/1ps

module tq_qp_split (
    input  logic                              clk_i,
    input  logic                              rst_n_i,
    input  logic                              valid_i,
    input  logic signed [tq_pkg::LEVEL_W-1:0] level00_i,
    input  logic signed [tq_pkg::LEVEL_W-1:0] level01_i,
    input  logic signed [tq_pkg::LEVEL_W-1:0] level10_i,
    input  logic signed [tq_pkg::LEVEL_W-1:0] level11_i,
    input  logic        [tq_pkg::QP_W-1:0]    qp_i,
    output logic                              valid_o,
    output logic signed [tq_pkg::LEVEL_W-1:0] level00_o,
    output logic signed [tq_pkg::LEVEL_W-1:0] level01_o,
    output logic signed [tq_pkg::LEVEL_W-1:0] level10_o,
    output logic signed [tq_pkg::LEVEL_W-1:0] level11_o,
    output logic        [tq_pkg::QPDIV_W-1:0] qpdiv6_o,
    output logic        [tq_pkg::QPMOD_W-1:0] qpmod6_o
);
    import tq_pkg::*;

    logic [QP_W-1:0]    rem_w;
    logic [QPDIV_W-1:0] div_w;

    // Restoring division by 6, trying 48, 24, 12 and 6 in turn.
    always_comb begin
        rem_w = qp_i;
        div_w = '0;
        for (int i = QPDIV_W - 1; i >= 0; i--) begin
            if (int'(rem_w) >= (6 << i)) begin
                rem_w    = rem_w - QP_W'(6 << i);
                div_w[i] = 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_o <= 1'b0;
        end else begin
            valid_o <= valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (valid_i) begin
            level00_o <= level00_i;
            level01_o <= level01_i;
            level10_o <= level10_i;
            level11_o <= level11_i;
            qpdiv6_o  <= div_w;
            qpmod6_o  <= rem_w[QPMOD_W-1:0];  // Remainder is below 6 here.
        end
    end

endmodule

//--- source/tq_ihadamard_2x2.sv
`timescale 1ns/1ps

module tq_ihadamard_2x2 (
    input  logic                              clk_i,
    input  logic                              rst_n_i,
    input  logic                              valid_i,
    input  logic signed [tq_pkg::LEVEL_W-1:0] level00_i,
    input  logic signed [tq_pkg::LEVEL_W-1:0] level01_i,
    input  logic signed [tq_pkg::LEVEL_W-1:0] level10_i,
    input  logic signed [tq_pkg::LEVEL_W-1:0] level11_i,
    input  logic        [tq_pkg::QPDIV_W-1:0] qpdiv6_i,
    input  logic        [tq_pkg::QPMOD_W-1:0] qpmod6_i,
    output logic                              valid_o,
    output logic signed [tq_pkg::COEFF_W-1:0] f00_o,
    output logic signed [tq_pkg::COEFF_W-1:0] f01_o,
    output logic signed [tq_pkg::COEFF_W-1:0] f10_o,
    output logic signed [tq_pkg::COEFF_W-1:0] f11_o,
    output logic        [tq_pkg::QPDIV_W-1:0] qpdiv6_o,
    output logic        [tq_pkg::QPMOD_W-1:0] qpmod6_o
);
    import tq_pkg::*;

    // Row butterflies, one bit of growth.
    logic signed [LEVEL_W:0]  r0_w;
    logic signed [LEVEL_W:0]  r1_w;
    logic signed [LEVEL_W:0]  r2_w;
    logic signed [LEVEL_W:0]  r3_w;
    logic signed [COEFF_W-1:0] f00_w;
    logic signed [COEFF_W-1:0] f01_w;
    logic signed [COEFF_W-1:0] f10_w;
    logic signed [COEFF_W-1:0] f11_w;

    assign r0_w = level00_i + level01_i;   // a + b.
    assign r1_w = level00_i - level01_i;   // a - b.
    assign r2_w = level10_i + level11_i;   // c + d.
    assign r3_w = level10_i - level11_i;   // c - d.

    // Column butterflies.
    assign f00_w = r0_w + r2_w;
    assign f01_w = r1_w + r3_w;
    assign f10_w = r0_w - r2_w;
    assign f11_w = r1_w - r3_w;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_o <= 1'b0;
        end else begin
            valid_o <= valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (valid_i) begin
            f00_o    <= f00_w;
            f01_o    <= f01_w;
            f10_o    <= f10_w;
            f11_o    <= f11_w;
            qpdiv6_o <= qpdiv6_i;   // Qp fields follow the block.
            qpmod6_o <= qpmod6_i;
        end
    end

endmodule

//--- source/tq_dequant_2x2.sv
`timescale 1ns/1ps

module tq_dequant_2x2 (
    input  logic        [2:0]  qpmod6_i,
    input  logic        [3:0]  qpdiv6_i,

    input  logic signed [14:0] scale00_i,
    input  logic signed [14:0] scale01_i,
    input  logic signed [14:0] scale10_i,
    input  logic signed [14:0] scale11_i,

    output logic signed [14:0] coeff00_o,
    output logic signed [14:0] coeff01_o,
    output logic signed [14:0] coeff10_o,
    output logic signed [14:0] coeff11_o
);

    logic        [4:0]  level_scale_w;
    logic signed [9:0]  mult_w;        // 16 times the level scale.
    logic        [3:0]  shift_len_w;
    logic               shift_right_w;

    logic signed [24:0] prod00_w;
    logic signed [24:0] prod01_w;
    logic signed [24:0] prod10_w;
    logic signed [24:0] prod11_w;

    logic signed [24:0] res00_w;
    logic signed [24:0] res01_w;
    logic signed [24:0] res10_w;
    logic signed [24:0] res11_w;

    always_comb begin
        case (qpmod6_i)
            3'd0:    level_scale_w = 5'd10;
            3'd1:    level_scale_w = 5'd11;
            3'd2:    level_scale_w = 5'd13;
            3'd3:    level_scale_w = 5'd14;
            3'd4:    level_scale_w = 5'd16;
            3'd5:    level_scale_w = 5'd18;
            default: level_scale_w = 5'd0;
        endcase
    end

    assign mult_w = {1'b0, level_scale_w, 4'b0000};

    assign shift_right_w = (qpdiv6_i < 4'd5);
    assign shift_len_w   = shift_right_w ? (4'd5 - qpdiv6_i) : (qpdiv6_i - 4'd5);

    assign prod00_w = scale00_i * mult_w;
    assign prod01_w = scale01_i * mult_w;
    assign prod10_w = scale10_i * mult_w;
    assign prod11_w = scale11_i * mult_w;

    assign res00_w = shift_right_w ? (prod00_w >>> shift_len_w) : (prod00_w <<< shift_len_w);
    assign res01_w = shift_right_w ? (prod01_w >>> shift_len_w) : (prod01_w <<< shift_len_w);
    assign res10_w = shift_right_w ? (prod10_w >>> shift_len_w) : (prod10_w <<< shift_len_w);
    assign res11_w = shift_right_w ? (prod11_w >>> shift_len_w) : (prod11_w <<< shift_len_w);

    // Low 15 bits only, no saturation.
    assign coeff00_o = res00_w[14:0];
    assign coeff01_o = res01_w[14:0];
    assign coeff10_o = res10_w[14:0];
    assign coeff11_o = res11_w[14:0];

endmodule

//--- source/tq_dc_credit_fifo.sv
`timescale 1ns/1ps

module tq_dc_credit_fifo #(
    parameter int FIFO_DEPTH  = 4,
    parameter int OUT_CREDITS = 2
) (
    input  logic                              clk_i,
    input  logic                              rst_n_i,
    input  logic                              wr_valid_i,
    input  logic signed [tq_pkg::COEFF_W-1:0] wr_coeff00_i,
    input  logic signed [tq_pkg::COEFF_W-1:0] wr_coeff01_i,
    input  logic signed [tq_pkg::COEFF_W-1:0] wr_coeff10_i,
    input  logic signed [tq_pkg::COEFF_W-1:0] wr_coeff11_i,
    output logic                              valid_o,
    output logic signed [tq_pkg::COEFF_W-1:0] coeff00_o,
    output logic signed [tq_pkg::COEFF_W-1:0] coeff01_o,
    output logic signed [tq_pkg::COEFF_W-1:0] coeff10_o,
    output logic signed [tq_pkg::COEFF_W-1:0] coeff11_o,
    output logic                              in_credit_o,
    input  logic                              out_credit_i
);
    import tq_pkg::*;

    localparam int PTR_W  = $clog2(FIFO_DEPTH);
    localparam int CNT_W  = $clog2(FIFO_DEPTH + 1);
    localparam int CRED_W = $clog2(OUT_CREDITS + 1);

    logic signed [COEFF_W-1:0] mem00_q [FIFO_DEPTH];
    logic signed [COEFF_W-1:0] mem01_q [FIFO_DEPTH];
    logic signed [COEFF_W-1:0] mem10_q [FIFO_DEPTH];
    logic signed [COEFF_W-1:0] mem11_q [FIFO_DEPTH];

    logic [PTR_W-1:0]  wr_ptr_q;
    logic [PTR_W-1:0]  rd_ptr_q;
    logic [CNT_W-1:0]  count_q;
    logic [CRED_W-1:0] credit_q;
    logic              pop_w;

    // Send when a block is held and downstream has room.
    assign pop_w = (count_q != '0) && (credit_q != '0);

    assign valid_o     = pop_w;
    assign in_credit_o = pop_w;   // Slot freed, upstream gets it back.
    assign coeff00_o   = mem00_q[rd_ptr_q];
    assign coeff01_o   = mem01_q[rd_ptr_q];
    assign coeff10_o   = mem10_q[rd_ptr_q];
    assign coeff11_o   = mem11_q[rd_ptr_q];

    always_ff @(posedge clk_i) begin
        if (wr_valid_i) begin
            mem00_q[wr_ptr_q] <= wr_coeff00_i;
            mem01_q[wr_ptr_q] <= wr_coeff01_i;
            mem10_q[wr_ptr_q] <= wr_coeff10_i;
            mem11_q[wr_ptr_q] <= wr_coeff11_i;
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
            credit_q <= CRED_W'(OUT_CREDITS);
        end else begin
            if (wr_valid_i) begin
                wr_ptr_q <= (wr_ptr_q == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (pop_w) begin
                rd_ptr_q <= (rd_ptr_q == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            count_q  <= count_q + CNT_W'(wr_valid_i) - CNT_W'(pop_w);
            // A pop and a returned credit may land in the same cycle.
            credit_q <= credit_q + CRED_W'(out_credit_i) - CRED_W'(pop_w);
        end
    end

endmodule

//--- source/tq_chroma_dc_top.sv
`timescale 1ns/1ps

module tq_chroma_dc_top #(
    parameter int FIFO_DEPTH  = 4,
    parameter int OUT_CREDITS = 2
) (
    input  logic                              clk_i,
    input  logic                              rst_n_i,
    input  logic                              valid_i,
    input  logic signed [tq_pkg::LEVEL_W-1:0] level00_i,
    input  logic signed [tq_pkg::LEVEL_W-1:0] level01_i,
    input  logic signed [tq_pkg::LEVEL_W-1:0] level10_i,
    input  logic signed [tq_pkg::LEVEL_W-1:0] level11_i,
    input  logic        [tq_pkg::QP_W-1:0]    qp_i,
    output logic                              in_credit_o,
    output logic                              valid_o,
    output logic signed [tq_pkg::COEFF_W-1:0] coeff00_o,
    output logic signed [tq_pkg::COEFF_W-1:0] coeff01_o,
    output logic signed [tq_pkg::COEFF_W-1:0] coeff10_o,
    output logic signed [tq_pkg::COEFF_W-1:0] coeff11_o,
    input  logic                              out_credit_i
);
    import tq_pkg::*;

    logic                      s1_valid;
    logic signed [LEVEL_W-1:0] s1_level00;
    logic signed [LEVEL_W-1:0] s1_level01;
    logic signed [LEVEL_W-1:0] s1_level10;
    logic signed [LEVEL_W-1:0] s1_level11;
    logic        [QPDIV_W-1:0] s1_qpdiv6;
    logic        [QPMOD_W-1:0] s1_qpmod6;

    logic                      s2_valid;
    logic signed [COEFF_W-1:0] s2_f00;
    logic signed [COEFF_W-1:0] s2_f01;
    logic signed [COEFF_W-1:0] s2_f10;
    logic signed [COEFF_W-1:0] s2_f11;
    logic        [QPDIV_W-1:0] s2_qpdiv6;
    logic        [QPMOD_W-1:0] s2_qpmod6;

    logic signed [COEFF_W-1:0] dq_coeff00;
    logic signed [COEFF_W-1:0] dq_coeff01;
    logic signed [COEFF_W-1:0] dq_coeff10;
    logic signed [COEFF_W-1:0] dq_coeff11;

    tq_qp_split u_qp_split (
        .clk_i     (clk_i),      .rst_n_i   (rst_n_i),    .valid_i   (valid_i),
        .level00_i (level00_i),  .level01_i (level01_i),
        .level10_i (level10_i),  .level11_i (level11_i),  .qp_i      (qp_i),
        .valid_o   (s1_valid),   .level00_o (s1_level00), .level01_o (s1_level01),
        .level10_o (s1_level10), .level11_o (s1_level11),
        .qpdiv6_o  (s1_qpdiv6),  .qpmod6_o  (s1_qpmod6)
    );

    tq_ihadamard_2x2 u_ihadamard (
        .clk_i     (clk_i),      .rst_n_i   (rst_n_i),    .valid_i   (s1_valid),
        .level00_i (s1_level00), .level01_i (s1_level01),
        .level10_i (s1_level10), .level11_i (s1_level11),
        .qpdiv6_i  (s1_qpdiv6),  .qpmod6_i  (s1_qpmod6),
        .valid_o   (s2_valid),   .f00_o     (s2_f00),     .f01_o     (s2_f01),
        .f10_o     (s2_f10),     .f11_o     (s2_f11),
        .qpdiv6_o  (s2_qpdiv6),  .qpmod6_o  (s2_qpmod6)
    );

    // Combinational, sits between stage 2 and the buffer.
    tq_dequant_2x2 u_dequant (
        .qpmod6_i  (s2_qpmod6),  .qpdiv6_i  (s2_qpdiv6),
        .scale00_i (s2_f00),     .scale01_i (s2_f01),
        .scale10_i (s2_f10),     .scale11_i (s2_f11),
        .coeff00_o (dq_coeff00), .coeff01_o (dq_coeff01),
        .coeff10_o (dq_coeff10), .coeff11_o (dq_coeff11)
    );

    tq_dc_credit_fifo #(
        .FIFO_DEPTH  (FIFO_DEPTH),
        .OUT_CREDITS (OUT_CREDITS)
    ) u_fifo (
        .clk_i        (clk_i),      .rst_n_i      (rst_n_i),    .wr_valid_i (s2_valid),
        .wr_coeff00_i (dq_coeff00), .wr_coeff01_i (dq_coeff01),
        .wr_coeff10_i (dq_coeff10), .wr_coeff11_i (dq_coeff11),
        .valid_o      (valid_o),    .coeff00_o    (coeff00_o),  .coeff01_o  (coeff01_o),
        .coeff10_o    (coeff10_o),  .coeff11_o    (coeff11_o),
        .in_credit_o  (in_credit_o), .out_credit_i (out_credit_i)
    );

endmodule

//--- include/tq_ref_model.svh
`ifndef TQ_REF_MODEL_SVH
`define TQ_REF_MODEL_SVH

// Maps any random word onto a legal qp.
function automatic int wrap_qp(input int unsigned x);
    return int'(x % (tq_pkg::QP_MAX + 1));
endfunction

function automatic int level_scale_of(input int qpmod6);
    case (qpmod6)
        0:       return 10;
        1:       return 11;
        2:       return 13;
        3:       return 14;
        4:       return 16;
        5:       return 18;
        default: return 0;
    endcase
endfunction

function automatic void inverse_hadamard(
    input  int a, input int b, input int c, input int d,
    output int f00, output int f01, output int f10, output int f11
);
    f00 = a + b + c + d;
    f01 = a - b + c - d;
    f10 = a + b - c - d;
    f11 = a - b - c + d;
endfunction

// Scale by 16 * level scale, shift by qp div 6 around 5, keep low bits.
function automatic logic signed [tq_pkg::COEFF_W-1:0] dequant_coeff(input int f, input int qp);
    int div6;
    int prod;
    logic signed [tq_pkg::COEFF_W-1:0] res;
    div6 = qp / 6;
    prod = f * 16 * level_scale_of(qp % 6);
    if (div6 < 5) begin
        prod = prod >>> (5 - div6);
    end else begin
        prod = prod <<< (div6 - 5);
    end
    res = prod[tq_pkg::COEFF_W-1:0];
    return res;
endfunction

`endif

//--- tests/tb_tq_chroma_dc.sv
`timescale 1ns/1ps

module tb_tq_chroma_dc;
    import tq_pkg::*;

    `include "tq_ref_model.svh"

    localparam int FIFO_DEPTH     = 4;
    localparam int OUT_CREDITS    = 2;
    localparam int CLK_PERIOD     = 40;
    localparam int NUM_BLOCKS     = 400;
    localparam int TIMEOUT_CYCLES = NUM_BLOCKS * 24 + 500;

    logic                      clk;
    logic                      rst_n_i;
    logic                      valid_i;
    logic signed [LEVEL_W-1:0] level00_i;
    logic signed [LEVEL_W-1:0] level01_i;
    logic signed [LEVEL_W-1:0] level10_i;
    logic signed [LEVEL_W-1:0] level11_i;
    logic        [QP_W-1:0]    qp_i;
    logic                      in_credit_o;
    logic                      valid_o;
    logic signed [COEFF_W-1:0] coeff00_o;
    logic signed [COEFF_W-1:0] coeff01_o;
    logic signed [COEFF_W-1:0] coeff10_o;
    logic signed [COEFF_W-1:0] coeff11_o;
    logic                      out_credit_i;

    logic [31:0]            lcg_state = 32'he87b4f5b;
    logic [4*COEFF_W-1:0]   exp_q[$];      // Expected blocks in sending order.
    int                     arrive_q[$];   // Cycle at which each block reaches the buffer.
    int                     pending_q[$];  // Cycles at which the consumer frees a slot.
    int                     dir_qp[9] = '{0, 5, 29, 30, 35, 51, 7, 20, 40};
    int cycle_cnt    = 0;
    int up_credits   = FIFO_DEPTH;
    int outstanding  = 0;
    int held_cnt     = 0;   // Blocks waiting in the output buffer.
    int last_release = 0;
    int sent_cnt     = 0;

    tq_chroma_dc_top #(
        .FIFO_DEPTH  (FIFO_DEPTH),
        .OUT_CREDITS (OUT_CREDITS)
    ) UUT (
        .clk_i     (clk),       .rst_n_i   (rst_n_i),   .valid_i      (valid_i),
        .level00_i (level00_i), .level01_i (level01_i),
        .level10_i (level10_i), .level11_i (level11_i), .qp_i         (qp_i),
        .in_credit_o (in_credit_o), .valid_o (valid_o),
        .coeff00_o (coeff00_o), .coeff01_o (coeff01_o),
        .coeff10_o (coeff10_o), .coeff11_o (coeff11_o), .out_credit_i (out_credit_i)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic signed [LEVEL_W-1:0] rand_level();
        logic [31:0] r;
        r = lcg_next();
        return r[LEVEL_W+15:16];   // Upper bits of the LCG word.
    endfunction

    task automatic stop_with_error(input string why);
        $display("%s", why);
        $display("Testbench failed");
        $fatal(1, "Run aborted.");
    endtask

    task automatic compare_coeff(input string name, input logic signed [COEFF_W-1:0] got,
                                 input logic signed [COEFF_W-1:0] exp);
        if (got !== exp)
            stop_with_error($sformatf("** Error: %s = 0x%h, expected 0x%h", name, got, exp));
    endtask

    task automatic compare_flag(input string name, input logic got, input logic exp);
        if (got !== exp)
            stop_with_error($sformatf("** Error: %s = 0x%h, expected 0x%h", name, got, exp));
    endtask

    // Samples outputs at the falling edge and then drives the next inputs.
    task automatic cycle_step();
        logic [4*COEFF_W-1:0] exp_blk;
        logic [31:0]          r;
        logic                 exp_pop;
        int                   release_at;
        @(negedge clk);
        cycle_cnt++;
        if (cycle_cnt > TIMEOUT_CYCLES)
            stop_with_error("Timeout: the run went past its cycle limit.");
        if (arrive_q.size() != 0 && arrive_q[0] <= cycle_cnt) begin
            void'(arrive_q.pop_front());
            held_cnt++;
        end
        // The head leaves when a block is held and downstream has a free slot.
        exp_pop = (held_cnt > 0) && (outstanding < OUT_CREDITS);
        compare_flag("valid_o", valid_o, exp_pop);
        compare_flag("in_credit_o", in_credit_o, exp_pop);
        if (exp_pop) begin
            held_cnt--;
            up_credits++;
            exp_blk = exp_q.pop_front();
            compare_coeff("coeff00_o", coeff00_o, exp_blk[4*COEFF_W-1 -: COEFF_W]);
            compare_coeff("coeff01_o", coeff01_o, exp_blk[3*COEFF_W-1 -: COEFF_W]);
            compare_coeff("coeff10_o", coeff10_o, exp_blk[2*COEFF_W-1 -: COEFF_W]);
            compare_coeff("coeff11_o", coeff11_o, exp_blk[COEFF_W-1 -: COEFF_W]);
            outstanding++;
            r = lcg_next();
            // Mostly short holds with a long one now and then.
            release_at = cycle_cnt + 1
                       + ((r[31:29] == 3'd0) ? 16 + int'(r[4:0]) : int'(r[3:0]));
            if (release_at <= last_release)
                release_at = last_release + 1;
            last_release = release_at;
            pending_q.push_back(release_at);
        end
        if (pending_q.size() != 0 && pending_q[0] <= cycle_cnt) begin
            void'(pending_q.pop_front());
            out_credit_i = 1'b1;
            outstanding--;
        end else begin
            out_credit_i = 1'b0;
        end
        valid_i = 1'b0;
    endtask

    task automatic send_block(input logic signed [LEVEL_W-1:0] l00,
                              input logic signed [LEVEL_W-1:0] l01,
                              input logic signed [LEVEL_W-1:0] l10,
                              input logic signed [LEVEL_W-1:0] l11,
                              input int qp);
        int f00;
        int f01;
        int f10;
        int f11;
        cycle_step();
        while (up_credits == 0)
            cycle_step();
        inverse_hadamard(int'(l00), int'(l01), int'(l10), int'(l11), f00, f01, f10, f11);
        exp_q.push_back({dequant_coeff(f00, qp), dequant_coeff(f01, qp),
                         dequant_coeff(f10, qp), dequant_coeff(f11, qp)});
        // Two register stages and the buffer write.
        arrive_q.push_back(cycle_cnt + 3);
        up_credits--;
        valid_i   = 1'b1;
        level00_i = l00;
        level01_i = l01;
        level10_i = l10;
        level11_i = l11;
        qp_i      = QP_W'(qp);
        sent_cnt++;
    endtask

    initial begin
        logic [31:0] r;
        clk          = 1'b0;
        rst_n_i      = 1'b1;
        valid_i      = 1'b0;
        level00_i    = '0;
        level01_i    = '0;
        level10_i    = '0;
        level11_i    = '0;
        qp_i         = '0;
        out_credit_i = 1'b0;
        #5 rst_n_i   = 1'b0;
        repeat (10) begin
            @(negedge clk);
            compare_flag("valid_o", valid_o, 1'b0);
            compare_flag("in_credit_o", in_credit_o, 1'b0);
        end
        rst_n_i = 1'b1;
        cycle_step();

        // Lone block into an idle pipeline, due on valid_o three cycles later.
        send_block(rand_level(), rand_level(), rand_level(), rand_level(), 28);
        repeat (3) cycle_step();

        foreach (dir_qp[i])
            send_block(13'sh0fff, 13'sh1000, rand_level(), rand_level(), dir_qp[i]);

        while (sent_cnt < NUM_BLOCKS) begin
            r = lcg_next();
            if (r[31:30] == 2'd0)
                repeat (int'(r[2:0])) cycle_step();
            send_block(rand_level(), rand_level(), rand_level(), rand_level(),
                       wrap_qp(lcg_next()));
        end

        while (exp_q.size() != 0 || pending_q.size() != 0)
            cycle_step();
        repeat (8) cycle_step();

        $display("Testbench passed");
        $finish;
    end

endmodule

//--- flist.f
+incdir+include
source/tq_pkg.sv
source/tq_qp_split.sv
source/tq_ihadamard_2x2.sv
source/tq_dequant_2x2.sv
source/tq_dc_credit_fifo.sv
source/tq_chroma_dc_top.sv
tests/tb_tq_chroma_dc.sv

//--- run_sim.sh
#!/bin/sh
# Builds the chroma DC testbench with Verilator and runs it.
# A $fatal in the testbench gives a non-zero exit status.
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
    --top-module tb_tq_chroma_dc \
    -f flist.f

./obj_dir/Vtb_tq_chroma_dc
